/* cx4_pkg.sv */
package cx4_pkg;

  ////////////////////
  // widths and types

  localparam int RAM_ADDR_W = 12;

  typedef logic [7:0]            byte_t;       // host / bus data byte
  typedef logic [12:0]           host_addr_t;  // host window offset
  typedef logic [RAM_ADDR_W-1:0] ram_addr_t;   // data ram index
  typedef logic [23:0]           addr24_t;     // bus address as host writes it
  typedef logic [22:0]           bus_addr_t;   // bank bits + low 15 bits
  typedef logic [15:0]           dma_len_t;    // 0 means 64k bytes

  typedef struct packed {
    addr24_t  source;
    dma_len_t length;
    addr24_t  target;
  } dma_cfg_t;

  typedef struct packed {
    logic      we;
    ram_addr_t addr;
    byte_t     data;
  } ram_wr_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_WAIT,
    ST_ADDR
  } dma_state_t;

  ////////////////////
  // host address map

  localparam int         DATRAM_TOP   = 'hC00;   // 3k bytes
  localparam logic [7:0] MMIO_PAGE    = 8'hFA;   // 0x1f40..0x1f5f
  localparam logic [4:0] STATUS_FIRST = 5'h13;   // 0x1f53 onward

  // mmio offsets within the page
  localparam logic [4:0] REG_DMASRC_L = 5'h00;
  localparam logic [4:0] REG_DMASRC_M = 5'h01;
  localparam logic [4:0] REG_DMASRC_H = 5'h02;
  localparam logic [4:0] REG_DMALEN_L = 5'h03;
  localparam logic [4:0] REG_DMALEN_H = 5'h04;
  localparam logic [4:0] REG_DMATGT_L = 5'h05;
  localparam logic [4:0] REG_DMATGT_M = 5'h06;
  localparam logic [4:0] REG_DMATGT_H = 5'h07;   // write kicks off dma
  localparam logic [4:0] REG_CFG50    = 5'h10;
  localparam logic [4:0] REG_CFG51    = 5'h11;
  localparam logic [4:0] REG_CFG52    = 5'h12;

  localparam byte_t CFG50_MASK  = 8'h77;
  localparam byte_t CFG50_RESET = 8'h33;
  localparam logic  CFG52_RESET = 1'b1;

endpackage

/* cx4_datram.sv */
`timescale 1ns/1ps

module cx4_datram
  import cx4_pkg::*;
(
  input  logic      CLK,
  input  logic      a_we,
  input  ram_addr_t a_addr,
  input  byte_t     a_di,
  output byte_t     a_do,
  input  ram_wr_t   b_wr,
  output byte_t     b_do
);

  byte_t mem [DATRAM_TOP];
  logic  b_in_range;

  // dma target wraps at 4k, top 1k has no storage
  assign b_in_range = (b_wr.addr < ram_addr_t'(DATRAM_TOP));

  always_ff @(posedge CLK) begin
    if (a_we) begin
      mem[a_addr] <= a_di;        // host port
    end
    if (b_wr.we && b_in_range) begin
      mem[b_wr.addr] <= b_wr.data;  // dma port
    end
    a_do <= mem[a_addr];
    b_do <= mem[b_wr.addr];
  end

endmodule

/* cx4_dma_counter.sv */
`timescale 1ns/1ps

module cx4_dma_counter
  import cx4_pkg::*;
(
  input  logic      CLK,
  input  logic      arst_n,
  input  dma_cfg_t  dma_cfg,
  input  logic      load,
  input  logic      ram_we,
  input  logic      step,
  output addr24_t   src,
  output ram_addr_t tgt,
  output logic      last
);

  dma_len_t count;
  dma_len_t remain;

  // bytes left once the byte in flight is written
  assign remain = count - 1'b1;
  assign last   = (remain == '0);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (load) begin
      count <= dma_cfg.length;     // 0 wraps to 64k
    end else if (ram_we) begin
      count <= remain;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      src <= '0;
      tgt <= '0;
    end else if (load) begin
      src <= dma_cfg.source;
      tgt <= dma_cfg.target[RAM_ADDR_W-1:0];
    end else if (step) begin
      src <= src + 1'b1;
      tgt <= tgt + 1'b1;           // wraps at 4k
    end
  end

endmodule

/* cx4_dma_fsm.sv */
`timescale 1ns/1ps

module cx4_dma_fsm
  import cx4_pkg::*;
(
  input  logic CLK,
  input  logic arst_n,
  input  logic dma_trig,
  input  logic bus_rdy,
  input  logic last,
  output logic load,
  output logic step,
  output logic bus_rrq,
  output logic ram_we,
  output logic busy
);

  dma_state_t state;
  logic       accept;

  // request must already be low before ready counts
  assign accept = !bus_rrq && bus_rdy;

  assign load = (state == ST_START);   // counter picks up cfg
  assign step = (state == ST_ADDR);    // bump src and tgt

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      bus_rrq <= 1'b0;
      ram_we  <= 1'b0;
      busy    <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (dma_trig) begin
            state <= ST_START;
          end
        end
        ST_START: begin
          busy    <= 1'b1;
          bus_rrq <= 1'b1;             // first byte request
          state   <= ST_WAIT;
        end
        ST_WAIT: begin
          bus_rrq <= 1'b0;
          if (accept) begin
            ram_we <= 1'b1;            // bus_di goes to ram next cycle
            state  <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          ram_we <= 1'b0;
          if (last) begin
            busy  <= 1'b0;
            state <= ST_IDLE;
          end else begin
            bus_rrq <= 1'b1;
            state   <= ST_WAIT;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

/* cx4_host_regs.sv */
`timescale 1ns/1ps

module cx4_host_regs
  import cx4_pkg::*;
(
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       cs,
  input  logic       reg_we_rising,
  input  host_addr_t host_addr,
  input  byte_t      host_di,
  input  byte_t      ram_do,
  input  logic       dma_busy,
  output byte_t      host_do,
  output logic       ram_host_we,
  output dma_cfg_t   dma_cfg,
  output logic       dma_trig
);

  logic [4:0] reg_off;
  logic       page_hit;
  logic       datram_en;
  logic       mmio_en;
  logic       status_en;
  logic       mmio_we;
  byte_t      cfg50;
  logic       cfg51;
  logic       cfg52;
  byte_t      mmio_do;
  byte_t      status_do;

  ////////////////////
  // region decode

  assign reg_off   = host_addr[4:0];
  assign page_hit  = (host_addr[12:5] == MMIO_PAGE);
  assign datram_en = cs && (host_addr < host_addr_t'(DATRAM_TOP));
  assign mmio_en   = cs && page_hit && (reg_off < STATUS_FIRST);
  assign status_en = cs && page_hit && (reg_off >= STATUS_FIRST);

  assign ram_host_we = datram_en && reg_we_rising;
  assign mmio_we     = mmio_en && reg_we_rising;

  ////////////////////
  // mmio registers

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      dma_cfg <= '0;
      cfg50   <= CFG50_RESET;
      cfg51   <= 1'b0;
      cfg52   <= CFG52_RESET;
    end else if (mmio_we) begin
      case (reg_off)
        REG_DMASRC_L: dma_cfg.source[7:0]   <= host_di;
        REG_DMASRC_M: dma_cfg.source[15:8]  <= host_di;
        REG_DMASRC_H: dma_cfg.source[23:16] <= host_di;
        REG_DMALEN_L: dma_cfg.length[7:0]   <= host_di;
        REG_DMALEN_H: dma_cfg.length[15:8]  <= host_di;
        REG_DMATGT_L: dma_cfg.target[7:0]   <= host_di;
        REG_DMATGT_M: dma_cfg.target[15:8]  <= host_di;
        REG_DMATGT_H: dma_cfg.target[23:16] <= host_di;
        REG_CFG50:    cfg50 <= host_di & CFG50_MASK;  // unused bits stay 0
        REG_CFG51:    cfg51 <= host_di[0];
        REG_CFG52:    cfg52 <= host_di[0];
        default: ;                                    // 0x08..0x0f ignored
      endcase
    end
  end

  // one cycle strobe after the 0x1f47 write
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      dma_trig <= 1'b0;
    end else begin
      dma_trig <= mmio_we && (reg_off == REG_DMATGT_H);
    end
  end

  ////////////////////
  // readback

  always_ff @(posedge CLK) begin
    case (reg_off)
      REG_DMASRC_L: mmio_do <= dma_cfg.source[7:0];
      REG_DMASRC_M: mmio_do <= dma_cfg.source[15:8];
      REG_DMASRC_H: mmio_do <= dma_cfg.source[23:16];
      REG_DMALEN_L: mmio_do <= dma_cfg.length[7:0];
      REG_DMALEN_H: mmio_do <= dma_cfg.length[15:8];
      REG_DMATGT_L: mmio_do <= dma_cfg.target[7:0];
      REG_DMATGT_M: mmio_do <= dma_cfg.target[15:8];
      REG_DMATGT_H: mmio_do <= dma_cfg.target[23:16];
      REG_CFG50:    mmio_do <= cfg50;
      REG_CFG51:    mmio_do <= {7'b0, cfg51};
      REG_CFG52:    mmio_do <= {7'b0, cfg52};
      default:      mmio_do <= 8'hFF;                 // unassigned offset
    endcase
  end

  // bit 6 active, bit 1 idle
  assign status_do = {1'b0, dma_busy, 4'b0000, ~dma_busy, 1'b0};

  always_comb begin
    if (datram_en) begin
      host_do = ram_do;           // registered in the ram
    end else if (mmio_en) begin
      host_do = mmio_do;
    end else if (status_en) begin
      host_do = status_do;        // live
    end else begin
      host_do = 8'h00;
    end
  end

endmodule

/* cx4.sv */
`timescale 1ns/1ps

module cx4
  import cx4_pkg::*;
(
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       cs,
  input  logic       reg_we_rising,
  input  host_addr_t host_addr,
  input  byte_t      host_di,
  output byte_t      host_do,
  input  byte_t      bus_di,
  output addr24_t    bus_addr,
  output logic       bus_rrq,
  input  logic       bus_rdy,
  output logic       cx4_active
);

  dma_cfg_t  dma_cfg;
  logic      dma_trig;
  logic      ram_host_we;
  byte_t     ram_do;
  logic      load;
  logic      step;
  logic      ram_we;
  logic      last;
  addr24_t   src;
  ram_addr_t tgt;
  ram_wr_t   ram_wr;
  bus_addr_t mapped_src;

  ////////////////////
  // bus side mapping

  assign mapped_src = {src[23:16], src[14:0]};   // bit 15 dropped
  assign bus_addr   = {1'b0, mapped_src};

  assign ram_wr.we   = ram_we;
  assign ram_wr.addr = tgt;
  assign ram_wr.data = bus_di;

  cx4_host_regs host_regs_inst (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .cs            (cs),
    .reg_we_rising (reg_we_rising),
    .host_addr     (host_addr),
    .host_di       (host_di),
    .ram_do        (ram_do),
    .dma_busy      (cx4_active),
    .host_do       (host_do),
    .ram_host_we   (ram_host_we),
    .dma_cfg       (dma_cfg),
    .dma_trig      (dma_trig)
  );

  cx4_dma_fsm dma_fsm_inst (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .dma_trig (dma_trig),
    .bus_rdy  (bus_rdy),
    .last     (last),
    .load     (load),
    .step     (step),
    .bus_rrq  (bus_rrq),
    .ram_we   (ram_we),
    .busy     (cx4_active)
  );

  cx4_dma_counter dma_counter_inst (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .dma_cfg (dma_cfg),
    .load    (load),
    .ram_we  (ram_we),
    .step    (step),
    .src     (src),
    .tgt     (tgt),
    .last    (last)
  );

  cx4_datram datram_inst (
    .CLK    (CLK),
    .a_we   (ram_host_we),
    .a_addr (host_addr[RAM_ADDR_W-1:0]),
    .a_di   (host_di),
    .a_do   (ram_do),
    .b_wr   (ram_wr),
    .b_do   ()                               // no reader without the cpu
  );

endmodule

/* tb_bus_model.sv */
`timescale 1ns/1ps

module tb_bus_model
  import cx4_pkg::*;
(
  input  logic    CLK,
  input  logic    arst_n,
  input  logic    bus_rrq,
  input  addr24_t bus_addr,
  output logic    bus_rdy,
  output byte_t   bus_di
);

  integer     seed = 71396;
  logic [2:0] wait_cnt;

  always @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      bus_rdy  <= 1'b1;
      bus_di   <= 8'h00;
      wait_cnt <= 3'd0;
    end else if (bus_rrq) begin
      bus_rdy  <= 1'b0;                                // drop on the request edge
      wait_cnt <= 3'd1 + 3'($random(seed) & 3);        // 1..4 cycles
      bus_di   <= bus_addr[7:0] ^ bus_addr[15:8];
    end else if (!bus_rdy) begin
      if (wait_cnt == 3'd1) begin
        bus_rdy <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt - 3'd1;
      end
    end
  end

endmodule

/* tb_cx4.sv */
`timescale 1ns/1ps

module tb_cx4
  import cx4_pkg::*;
();

  localparam int OP_WR   = 0;
  localparam int OP_RD   = 1;   // read and compare
  localparam int OP_DMA  = 2;
  localparam int OP_IDLE = 3;   // cx4_active must be low now

  typedef struct packed {
    logic [1:0]  op;
    logic [23:0] a;             // host address or dma source
    logic [15:0] b;             // write data or dma length
    logic [11:0] t;             // dma target
    logic [7:0]  exp;
  } op_t;

  logic       CLK;
  logic       arst_n;
  logic       cs;
  logic       reg_we_rising;
  host_addr_t host_addr;
  byte_t      host_di;
  byte_t      host_do;
  byte_t      bus_di;
  addr24_t    bus_addr;
  logic       bus_rrq;
  logic       bus_rdy;
  logic       cx4_active;

  op_t ops [0:63];
  int  n_ops = 0;
  int  cycles = 0;
  int  limit = 100000;
  int  passed = 0;
  int  failed = 0;

  cx4 cx4_inst (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .cs            (cs),
    .reg_we_rising (reg_we_rising),
    .host_addr     (host_addr),
    .host_di       (host_di),
    .host_do       (host_do),
    .bus_di        (bus_di),
    .bus_addr      (bus_addr),
    .bus_rrq       (bus_rrq),
    .bus_rdy       (bus_rdy),
    .cx4_active    (cx4_active)
  );

  tb_bus_model bus_model_inst (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .bus_rrq  (bus_rrq),
    .bus_addr (bus_addr),
    .bus_rdy  (bus_rdy),
    .bus_di   (bus_di)
  );

  always #10 CLK = ~CLK;  // 20 ns period

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout, run exceeded %0d cycles", limit);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////
  // stimulus helpers

  task automatic add_op(input int op, input logic [23:0] a, input logic [15:0] b,
                        input logic [11:0] t, input logic [7:0] exp);
    ops[n_ops] = '{op: op[1:0], a: a, b: b, t: t, exp: exp};
    n_ops++;
  endtask

  task automatic host_write(input logic [12:0] a, input logic [7:0] d);
    @(posedge CLK);
    host_addr     <= a;
    host_di       <= d;
    reg_we_rising <= 1'b1;
    @(posedge CLK);
    reg_we_rising <= 1'b0;  // write lands on this edge
  endtask

  task automatic host_read(input logic [12:0] a, output logic [7:0] d);
    @(posedge CLK);
    host_addr <= a;
    @(posedge CLK);
    @(negedge CLK);
    d = host_do;
  endtask

  task automatic check_byte(input int idx, input logic [12:0] a,
                            input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("ERR test %0d host_do addr 0x%03h got 0x%02h exp 0x%02h", idx, a, got, exp);
      failed++;
    end else begin
      $display("test %0d read 0x%03h ok", idx, a);
      passed++;
    end
  endtask

  task automatic run_dma(input int idx, input op_t o);
    logic [7:0] st;
    host_write(13'h1F40, o.a[7:0]);
    host_write(13'h1F41, o.a[15:8]);
    host_write(13'h1F42, o.a[23:16]);
    host_write(13'h1F43, o.b[7:0]);
    host_write(13'h1F44, o.b[15:8]);
    host_write(13'h1F45, o.t[7:0]);
    host_write(13'h1F46, {4'h0, o.t[11:8]});
    host_write(13'h1F47, 8'h00);               // starts the transfer
    while (!cx4_active) @(negedge CLK);
    host_read(13'h1F53, st);
    while (cx4_active) @(negedge CLK);
    if (st !== 8'h40) begin
      $display("ERR test %0d host_do status during dma got 0x%02h exp 0x40", idx, st);
      failed++;
    end else begin
      $display("test %0d dma of %0d bytes ok", idx, o.b);
      passed++;
    end
  endtask

  ////////////////////
  // table and main loop

  initial begin
    logic [7:0] got;
    int         dma_bytes;
    CLK = 1'b0;
    arst_n = 1'b0;
    cs = 1'b1;
    reg_we_rising = 1'b0;
    host_addr = '0;
    host_di = '0;

    add_op(OP_RD, 24'h1F50, 0, 0, 8'h33);      // reset values
    add_op(OP_RD, 24'h1F52, 0, 0, 8'h01);
    add_op(OP_RD, 24'h1F53, 0, 0, 8'h02);
    add_op(OP_IDLE, 0, 0, 0, 0);
    add_op(OP_WR, 24'h1F40, 16'hA1, 0, 0);
    add_op(OP_WR, 24'h1F41, 16'hB2, 0, 0);
    add_op(OP_WR, 24'h1F42, 16'hC3, 0, 0);
    add_op(OP_WR, 24'h1F43, 16'h01, 0, 0);
    add_op(OP_WR, 24'h1F44, 16'h5D, 0, 0);
    add_op(OP_WR, 24'h1F45, 16'h80, 0, 0);
    add_op(OP_WR, 24'h1F46, 16'h0E, 0, 0);
    add_op(OP_RD, 24'h1F40, 0, 0, 8'hA1);
    add_op(OP_RD, 24'h1F41, 0, 0, 8'hB2);
    add_op(OP_RD, 24'h1F42, 0, 0, 8'hC3);
    add_op(OP_RD, 24'h1F43, 0, 0, 8'h01);
    add_op(OP_RD, 24'h1F44, 0, 0, 8'h5D);
    add_op(OP_RD, 24'h1F45, 0, 0, 8'h80);
    add_op(OP_RD, 24'h1F46, 0, 0, 8'h0E);
    // length back to 1 and target 0xe80 so the 0x1f47 write moves one byte to nowhere
    add_op(OP_WR, 24'h1F44, 16'h00, 0, 0);
    add_op(OP_WR, 24'h1F47, 16'hF7, 0, 0);
    add_op(OP_RD, 24'h1F44, 0, 0, 8'h00);
    add_op(OP_RD, 24'h1F47, 0, 0, 8'hF7);
    add_op(OP_WR, 24'h1F50, 16'hFF, 0, 0);
    add_op(OP_RD, 24'h1F50, 0, 0, 8'h77);      // masked
    add_op(OP_RD, 24'h1F48, 0, 0, 8'hFF);      // unassigned
    add_op(OP_WR, 24'h0000, 16'h5A, 0, 0);     // host data ram
    add_op(OP_WR, 24'h0BFF, 16'hC3, 0, 0);
    add_op(OP_WR, 24'h0123, 16'h9E, 0, 0);
    add_op(OP_RD, 24'h0000, 0, 0, 8'h5A);
    add_op(OP_RD, 24'h0BFF, 0, 0, 8'hC3);
    add_op(OP_RD, 24'h0123, 0, 0, 8'h9E);
    add_op(OP_RD, 24'h0D00, 0, 0, 8'h00);      // gap above the ram
    add_op(OP_WR, 24'h0105, 16'hA5, 0, 0);     // marker past the transfer
    add_op(OP_DMA, 24'h123456, 16'd5, 12'h100, 0);
    add_op(OP_RD, 24'h1F53, 0, 0, 8'h02);
    add_op(OP_RD, 24'h0100, 0, 0, 8'h62);      // 0x56 ^ 0x34 onward
    add_op(OP_RD, 24'h0101, 0, 0, 8'h63);
    add_op(OP_RD, 24'h0102, 0, 0, 8'h6C);
    add_op(OP_RD, 24'h0103, 0, 0, 8'h6D);
    add_op(OP_RD, 24'h0104, 0, 0, 8'h6E);
    add_op(OP_RD, 24'h0105, 0, 0, 8'hA5);
    add_op(OP_DMA, 24'h017FFE, 16'd4, 12'h200, 0);
    add_op(OP_RD, 24'h0200, 0, 0, 8'h01);      // mapped 0x00fffe
    add_op(OP_RD, 24'h0201, 0, 0, 8'h00);
    add_op(OP_RD, 24'h0202, 0, 0, 8'h80);      // mapped 0x008000
    add_op(OP_RD, 24'h0203, 0, 0, 8'h81);
    add_op(OP_IDLE, 0, 0, 0, 0);

    dma_bytes = 1;
    for (int i = 0; i < n_ops; i++) begin
      if (ops[i].op == OP_DMA) dma_bytes += ops[i].b;
    end
    limit = 20 + n_ops * 30 + dma_bytes * 10;  // worst byte is about 7 cycles

    repeat (10) @(posedge CLK);
    arst_n <= 1'b1;

    for (int i = 0; i < n_ops; i++) begin
      case (ops[i].op)
        OP_WR: begin
          host_write(ops[i].a[12:0], ops[i].b[7:0]);
          $display("test %0d write 0x%03h done", i, ops[i].a[12:0]);
        end
        OP_RD: begin
          host_read(ops[i].a[12:0], got);
          check_byte(i, ops[i].a[12:0], got, ops[i].exp);
        end
        OP_DMA: run_dma(i, ops[i]);
        default: begin
          @(negedge CLK);
          if (cx4_active !== 1'b0) begin
            $display("ERR test %0d cx4_active got 0x%0h exp 0x0", i, cx4_active);
            failed++;
          end else begin
            $display("test %0d idle ok", i);
            passed++;
          end
        end
      endcase
    end

    $display("%0d tests passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* all.f */
cx4_pkg.sv
cx4_datram.sv
cx4_dma_counter.sv
cx4_dma_fsm.sv
cx4_host_regs.sv
cx4.sv
tb_bus_model.sv
tb_cx4.sv

/* run.sh */
#!/bin/sh
# Build and run the cx4 testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_cx4 -o sim_cx4
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_cx4)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1
